/* flist.f */
src/ac97_pkg.sv
src/codec_cmd_seq.sv
src/pcm_mixer.sv
src/slot_latch.sv
src/frame_serializer.sv
src/ac97_top.sv
verif/tb_clock_gen.sv
verif/ac97_checker.sv
verif/ac97_tb.sv

/* run.sh */
#!/bin/sh
# Builds the AC97 link testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module ac97_tb \
	-f flist.f -o ac97_sim > build.log 2>&1 \
	&& ./obj_dir/ac97_sim > sim.log 2>&1 \
	|| echo "Build or simulation did not complete, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -qx "Result: PASSED" sim.log && echo "Simulation passed" && exit 0 \
	|| { echo "Simulation failed"; exit 1; }

/* src/ac97_pkg.sv */
// Shared definitions for the AC97 controller link
// Frame geometry, codec register map, sequencer states
// and the packed structs passed between the blocks

package ac97_pkg;

	localparam int frame_bits    = 256;
	localparam int tag_bits      = 16;
	localparam int slot_bits     = 20;
	localparam int sync_high_end = 14;  // Sync falls after this tag bit
	localparam int level_bits    = 4;
	localparam int num_channels  = 3;
	localparam int addr_bits     = 7;
	localparam int data_bits     = 16;
	localparam int sum_bits      = 6;   // Three 4-bit levels never exceed 45

	// Tag plus slots 1 to 4, the only part of the frame that carries data
	localparam int head_bits = tag_bits + 4 * slot_bits;

	// Frame valid, slots 1 to 4 valid, everything else empty
	localparam logic [tag_bits-1:0] tag_pattern = 16'b1111_1000_0000_0000;

	// Codec register map
	localparam logic [addr_bits-1:0] reg_reset      = 7'h00;
	localparam logic [addr_bits-1:0] reg_master_vol = 7'h02;
	localparam logic [addr_bits-1:0] reg_pcm_vol    = 7'h18;
	localparam logic [addr_bits-1:0] reg_power      = 7'h26;
	localparam logic [addr_bits-1:0] reg_vid0       = 7'h7c;
	localparam logic [addr_bits-1:0] reg_vid1       = 7'h7e;

	localparam logic [data_bits-1:0] pcm_vol_0db = 16'h0808;  // Unmuted, 0 dB

	typedef logic [7:0] bit_cnt_t;
	typedef logic [slot_bits-1:0] slot_t;

	typedef enum logic [2:0] {
		cfg_reset,
		cfg_master_vol,
		cfg_pcm_vol,
		cfg_power,
		cfg_vid0,
		cfg_vid1
	} cfg_state_e;

	typedef struct packed {
		slot_t addr_slot;  // Read flag, address, 12 reserved zeros
		slot_t data_slot;  // Data word, 4 reserved zeros
	} codec_cmd_t;

	typedef struct packed {
		logic [level_bits-1:0] ch1;
		logic [level_bits-1:0] ch2;
		logic [level_bits-1:0] ch3;
	} ch_levels_t;

	// Enable bit 0 is ch1, bit 2 is ch3
	typedef struct packed {
		logic                    master;
		logic [num_channels-1:0] left_en;
		logic [num_channels-1:0] right_en;
		logic [level_bits-1:0]   shift;
	} mix_ctrl_t;

	typedef struct packed {
		slot_t left;
		slot_t right;
	} pcm_pair_t;

	typedef struct packed {
		codec_cmd_t cmd;
		pcm_pair_t  pcm;
	} frame_slots_t;

endpackage

/* src/ac97_top.sv */
// AC97 controller link top level
// Command sequencer and PCM mixer feed the slot latch,
// which the frame serializer sends out on the AC-link

module ac97_top
	import ac97_pkg::*;
(
	input  logic       ac97_bitclk,
	input  logic       rst_n,
	input  mix_ctrl_t  mix,
	input  ch_levels_t levels,
	output logic       ac97_sync,
	output logic       ac97_sdata_out,
	output logic       frame_start
);

	codec_cmd_t   cmd;
	pcm_pair_t    pcm;
	frame_slots_t slots;

	codec_cmd_seq seq_i (
		.ac97_bitclk (ac97_bitclk),
		.rst_n       (rst_n),
		.frame_start (frame_start),
		.cmd         (cmd)
	);

	pcm_mixer mixer_i (
		.mix    (mix),
		.levels (levels),
		.pcm    (pcm)
	);

	// Holds slots 1 to 4 for one whole frame
	slot_latch latch_i (
		.ac97_bitclk (ac97_bitclk),
		.rst_n       (rst_n),
		.frame_start (frame_start),
		.cmd         (cmd),
		.pcm         (pcm),
		.slots       (slots)
	);

	frame_serializer ser_i (
		.ac97_bitclk    (ac97_bitclk),
		.rst_n          (rst_n),
		.slots          (slots),
		.frame_start    (frame_start),
		.ac97_sync      (ac97_sync),
		.ac97_sdata_out (ac97_sdata_out)
	);

endmodule

/* src/codec_cmd_seq.sv */
// Codec command sequencer
// Power-up writes to reset, master and PCM volume, then a
// repeating cycle of status and vendor ID reads, one per frame

module codec_cmd_seq
	import ac97_pkg::*;
(
	input  logic       ac97_bitclk,
	input  logic       rst_n,
	input  logic       frame_start,
	output codec_cmd_t cmd
);

	cfg_state_e state;
	cfg_state_e state_nxt;

	// Packs one AC97 command into its two slots
	function automatic codec_cmd_t make_cmd(input logic rd,
	                                        input logic [addr_bits-1:0] addr,
	                                        input logic [data_bits-1:0] data);
		codec_cmd_t c;
		c.addr_slot = {rd, addr, 12'h000};
		c.data_slot = {data, 4'h0};
		return c;
	endfunction

	always_comb begin
		case (state)
			cfg_reset:      state_nxt = cfg_master_vol;
			cfg_master_vol: state_nxt = cfg_pcm_vol;
			cfg_pcm_vol:    state_nxt = cfg_power;
			cfg_power:      state_nxt = cfg_vid0;
			cfg_vid0:       state_nxt = cfg_vid1;
			default:        state_nxt = cfg_power;  // Read loop restarts
		endcase
	end

	always_ff @(posedge ac97_bitclk or negedge rst_n) begin
		if (!rst_n) begin
			state <= cfg_reset;
		end else if (frame_start) begin
			state <= state_nxt;
		end
	end

	// Writes carry rd = 0, reads have an empty data slot
	always_comb begin
		case (state)
			cfg_reset:      cmd = make_cmd(1'b0, reg_reset, 16'h0000);
			cfg_master_vol: cmd = make_cmd(1'b0, reg_master_vol, 16'h0000);
			cfg_pcm_vol:    cmd = make_cmd(1'b0, reg_pcm_vol, pcm_vol_0db);
			cfg_power:      cmd = make_cmd(1'b1, reg_power, 16'h0000);
			cfg_vid0:       cmd = make_cmd(1'b1, reg_vid0, 16'h0000);
			default:        cmd = make_cmd(1'b1, reg_vid1, 16'h0000);
		endcase
	end

endmodule

/* src/frame_serializer.sv */
// AC-link frame serializer
// Bit counter, sync generation, frame start strobe and
// serial data selection for the tag and slots 1 to 4

module frame_serializer
	import ac97_pkg::*;
(
	input  logic         ac97_bitclk,
	input  logic         rst_n,
	input  frame_slots_t slots,
	output logic         frame_start,
	output logic         ac97_sync,
	output logic         ac97_sdata_out
);

	bit_cnt_t bit_cnt;

	logic [head_bits-1:0] head;
	logic [head_bits-1:0] head_shift;

	// Bit position on the link wraps at the frame length
	always_ff @(posedge ac97_bitclk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= '0;
		end else begin
			bit_cnt <= bit_cnt + 8'd1;
		end
	end

	assign frame_start = (bit_cnt == '0);

	// High across the tag and over the last bit of the previous frame
	always_comb begin
		ac97_sync = 1'b0;
		if (int'(bit_cnt) <= sync_high_end) begin
			ac97_sync = 1'b1;
		end
		if (int'(bit_cnt) == frame_bits - 1) begin
			ac97_sync = 1'b1;
		end
	end

	// Tag then slots 1 to 4 in transmit order
	assign head = {tag_pattern, slots};

	assign head_shift = head << bit_cnt;  // Current bit lands in the MSB

	// Slots 5 to 12 shift out as zeros
	assign ac97_sdata_out = head_shift[head_bits-1];

endmodule

/* src/pcm_mixer.sv */
// PCM mixer for the left and right output slots
// Sums the enabled channel levels per side and scales by the volume shift

module pcm_mixer
	import ac97_pkg::*;
(
	input  mix_ctrl_t  mix,
	input  ch_levels_t levels,
	output pcm_pair_t  pcm
);

	slot_t left_mix;
	slot_t right_mix;

	// One side of the mix, the shift keeps only the low slot bits
	function automatic slot_t mix_side(input logic [num_channels-1:0] en,
	                                   input ch_levels_t lv,
	                                   input logic [level_bits-1:0] sh);
		logic [sum_bits-1:0] sum;
		slot_t wide;
		sum = '0;
		if (en[0]) begin
			sum = sum + sum_bits'(lv.ch1);
		end
		if (en[1]) begin
			sum = sum + sum_bits'(lv.ch2);
		end
		if (en[2]) begin
			sum = sum + sum_bits'(lv.ch3);
		end
		wide = slot_bits'(sum);
		return wide << sh;
	endfunction

	always_comb begin
		left_mix  = mix_side(mix.left_en, levels, mix.shift);
		right_mix = mix_side(mix.right_en, levels, mix.shift);
	end

	// Master enable silences both sides
	always_comb begin
		if (mix.master) begin
			pcm.left  = left_mix;
			pcm.right = right_mix;
		end else begin
			pcm.left  = '0;
			pcm.right = '0;
		end
	end

endmodule

/* src/slot_latch.sv */
// Frame slot holding register
// Captures the command and PCM words together at frame start
// so that one frame never mixes old and new data

module slot_latch
	import ac97_pkg::*;
(
	input  logic         ac97_bitclk,
	input  logic         rst_n,
	input  logic         frame_start,
	input  codec_cmd_t   cmd,
	input  pcm_pair_t    pcm,
	output frame_slots_t slots
);

	frame_slots_t slots_q;

	always_ff @(posedge ac97_bitclk or negedge rst_n) begin
		if (!rst_n) begin
			slots_q <= '0;
		end else if (frame_start) begin
			slots_q.cmd <= cmd;  // Loaded at the end of bit 0
			slots_q.pcm <= pcm;
		end
	end

	assign slots = slots_q;

endmodule

/* verif/ac97_checker.sv */
// AC-link frame checker
// Collects each 256-bit frame on falling edges together with the mixer
// inputs latched for it, rebuilds the expected frame and compares

module ac97_checker
	import ac97_pkg::*;
(
	input  logic       ac97_bitclk,
	input  logic       rst_n,
	input  mix_ctrl_t  mix,
	input  ch_levels_t levels,
	input  logic       ac97_sync,
	input  logic       ac97_sdata_out,
	input  logic       frame_start,
	input  int         num_frames,
	output logic       done,
	output int         error_count,
	output int         frames_checked
);

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		logic [255:0] data;  // Bit 0 of the frame in the MSB
		logic [255:0] sync;
		mix_ctrl_t    mix;
		ch_levels_t   levels;
	} captured_t;

	captured_t    cap_q[$];
	captured_t    cap_in;
	event         frame_ready;
	logic [255:0] data_q = '0;
	logic [255:0] sync_q = '0;
	bit           started = 1'b0;
	int           pos = 0;
	int           mismatch_count = 0;
	int           framing_errors = 0;
	int           coverage_gaps = 0;

	// Sum of enabled levels scaled and cut to 20 bits
	function automatic logic [19:0] expected_pcm(input logic master, input logic [2:0] en,
	                                             input ch_levels_t lv, input logic [3:0] shift);
		int sum;
		sum = 0;
		if (en[0]) sum += int'(lv.ch1);
		if (en[1]) sum += int'(lv.ch2);
		if (en[2]) sum += int'(lv.ch3);
		if (!master) return 20'h0;
		return 20'(sum << shift);
	endfunction

	// Whole frame as sent with the tag first
	function automatic logic [255:0] expected_frame(input int idx, input mix_ctrl_t m,
	                                                input ch_levels_t lv);
		logic        rd;
		logic [6:0]  addr;
		logic [15:0] data;
		logic [19:0] s3;
		logic [19:0] s4;
		rd   = 1'b1;
		data = 16'h0000;
		if (idx == 0) begin
			rd   = 1'b0;
			addr = 7'h00;
		end else if (idx == 1) begin
			rd   = 1'b0;
			addr = 7'h02;
		end else if (idx == 2) begin
			rd   = 1'b0;
			addr = 7'h18;
			data = 16'h0808;
		end else begin
			case ((idx - 3) % 3)
				0:       addr = 7'h26;
				1:       addr = 7'h7c;
				default: addr = 7'h7e;
			endcase
		end
		s3 = expected_pcm(m.master, m.left_en, lv, m.shift);
		s4 = expected_pcm(m.master, m.right_en, lv, m.shift);
		return {16'hf800, rd, addr, 12'h000, data, 4'h0, s3, s4, 160'h0};
	endfunction

	function automatic string cmd_name(input int idx);
		if (idx == 0) return "reset write";
		if (idx == 1) return "master volume write";
		if (idx == 2) return "PCM volume write";
		case ((idx - 3) % 3)
			0:       return "power status read";
			1:       return "vendor ID 0 read";
			default: return "vendor ID 1 read";
		endcase
	endfunction

	task automatic compare_field(input string sig, input int frame, input logic [255:0] expected,
	                             input logic [255:0] actual, inout int mismatches);
		if (expected !== actual) begin
			$display("[ERROR] %0d ns %s frame %0d: expected %0h, actual %0h",
			         $time, sig, frame, expected, actual);
			mismatches++;
		end
	endtask

	task automatic check_frame(input int idx, input captured_t c, output int mismatches);
		logic [255:0] exp;
		logic [255:0] exp_sync;
		exp      = expected_frame(idx, c.mix, c.levels);
		exp_sync = {{15{1'b1}}, 240'h0, 1'b1};  // Bits 0 to 14 and 255
		mismatches = 0;
		compare_field("ac97_sdata_out tag", idx, 256'(exp[255:240]),
		              256'(c.data[255:240]), mismatches);
		compare_field("ac97_sdata_out slot 1", idx, 256'(exp[239:220]),
		              256'(c.data[239:220]), mismatches);
		compare_field("ac97_sdata_out slot 2", idx, 256'(exp[219:200]),
		              256'(c.data[219:200]), mismatches);
		compare_field("ac97_sdata_out slot 3", idx, 256'(exp[199:180]),
		              256'(c.data[199:180]), mismatches);
		compare_field("ac97_sdata_out slot 4", idx, 256'(exp[179:160]),
		              256'(c.data[179:160]), mismatches);
		compare_field("ac97_sdata_out slots 5 to 12", idx, 256'(exp[159:0]),
		              256'(c.data[159:0]), mismatches);
		compare_field("ac97_sync", idx, exp_sync, c.sync, mismatches);
	endtask

	// Frames are collected on the falling edge where inputs are stable
	always @(negedge ac97_bitclk) begin
		if (rst_n) begin
			if (frame_start) begin
				if (started) begin
					if (pos != frame_bits) begin
						$display("%0d ns: frame_start came %0d cycles after the last one, not 256",
						         $time, pos);
						framing_errors++;
					end
					cap_in.data = data_q;
					cap_in.sync = sync_q;
					cap_q.push_back(cap_in);
					-> frame_ready;
				end
				started       = 1'b1;
				pos           = 0;
				data_q        = '0;
				sync_q        = '0;
				cap_in.mix    = mix;  // What the latch takes at the end of bit 0
				cap_in.levels = levels;
			end else if (started && pos == frame_bits) begin
				$display("%0d ns: frame_start missing after 256 cycles", $time);
				framing_errors++;
			end
			if (started && pos < frame_bits) begin
				data_q[frame_bits-1-pos] = ac97_sdata_out;
				sync_q[frame_bits-1-pos] = ac97_sync;
			end
			if (started) pos++;
		end
	end

	initial begin : compare
		captured_t  c;
		int         mm;
		logic [7:0] left_seen;
		logic [7:0] right_seen;
		int         muted_frames;
		done           = 1'b0;
		error_count    = 0;
		frames_checked = 0;
		left_seen      = '0;
		right_seen     = '0;
		muted_frames   = 0;
		for (int f = 0; f < num_frames; f++) begin
			while (cap_q.size() == 0) @(frame_ready);
			c = cap_q.pop_front();
			check_frame(f, c, mm);
			mismatch_count += mm;
			frames_checked++;
			if (c.mix.master) begin
				left_seen[c.mix.left_en]   = 1'b1;
				right_seen[c.mix.right_en] = 1'b1;
			end else begin
				muted_frames++;
			end
			if (mm == 0) begin
				$display("frame %0d, %s, master %0b: ok", f, cmd_name(f), c.mix.master);
			end else begin
				$display("frame %0d, %s, master %0b: %0d mismatches", f, cmd_name(f),
				         c.mix.master, mm);
			end
		end
		if (left_seen != 8'hff || right_seen != 8'hff) begin
			$display("Not every enable pattern was sent with master on");
			coverage_gaps++;
		end
		if (muted_frames == 0) begin
			$display("No frame was sent with master off");
			coverage_gaps++;
		end
		$display("Checked %0d of %0d frames: %0d mismatches, %0d framing errors, %0d coverage gaps",
		         frames_checked, num_frames, mismatch_count, framing_errors, coverage_gaps);
		error_count = mismatch_count + framing_errors + coverage_gaps;
		done = 1'b1;
	end

endmodule

/* verif/ac97_tb.sv */
// AC97 controller link testbench top
// Clock source, DUT, frame checker, LFSR driven mixer stimulus
// and the watchdog that bounds the run

module ac97_tb
	import ac97_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int          num_frames    = 40;
	localparam int          bit_period_ns = 40;
	localparam longint      timeout_ns    = longint'(num_frames) * 256 * bit_period_ns
	                                        + 20 * bit_period_ns;
	localparam logic [31:0] lfsr_seed     = 32'h378b_f693;

	logic       ac97_bitclk;
	logic       rst_n;
	mix_ctrl_t  mix;
	ch_levels_t levels;
	logic       ac97_sync;
	logic       ac97_sdata_out;
	logic       frame_start;
	logic       chk_done;
	int         error_count;
	int         frames_checked;

	logic [31:0] lfsr_state;
	int          stim_idx;

	// Fibonacci LFSR, taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int n, output logic [15:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[14:0], lfsr_state[0]};
		end
	endtask

	// Stimulus idx is the one that frame idx carries
	task automatic drive_stimulus(input int idx);
		logic [15:0] lv_bits;
		logic [15:0] sh_bits;
		logic [4:0]  idx_bits;
		take_bits(12, lv_bits);
		take_bits(4, sh_bits);
		idx_bits = idx[4:0];
		levels       <= lv_bits[11:0];
		mix.master   <= (idx % 4 != 3);  // Every fourth frame muted
		mix.left_en  <= idx_bits[4:2];  // Walks all eight patterns
		mix.right_en <= idx_bits[4:2] ^ 3'b101;
		mix.shift    <= sh_bits[3:0];
	endtask

	tb_clock_gen clk_gen_i (
		.ac97_bitclk (ac97_bitclk),
		.rst_n       (rst_n)
	);

	ac97_top dut_i (
		.ac97_bitclk    (ac97_bitclk),
		.rst_n          (rst_n),
		.mix            (mix),
		.levels         (levels),
		.ac97_sync      (ac97_sync),
		.ac97_sdata_out (ac97_sdata_out),
		.frame_start    (frame_start)
	);

	ac97_checker checker_i (
		.ac97_bitclk    (ac97_bitclk),
		.rst_n          (rst_n),
		.mix            (mix),
		.levels         (levels),
		.ac97_sync      (ac97_sync),
		.ac97_sdata_out (ac97_sdata_out),
		.frame_start    (frame_start),
		.num_frames     (num_frames),
		.done           (chk_done),
		.error_count    (error_count),
		.frames_checked (frames_checked)
	);

	// New inputs on the edge that ends bit 0, so they land in the next frame
	initial begin : stimulus
		lfsr_state = lfsr_seed;
		drive_stimulus(0);
		stim_idx = 1;
		forever begin
			@(posedge ac97_bitclk);
			if (rst_n && frame_start) begin
				drive_stimulus(stim_idx);
				stim_idx++;
			end
		end
	end

	initial begin : finish_run
		wait (chk_done);
		if (error_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		#(timeout_ns);
		$display("Watchdog timeout: frame_start stopped arriving, %0d of %0d frames checked",
		         frames_checked, num_frames);
		$display("Result: FAILED");
		$finish;
	end

endmodule

/* verif/tb_clock_gen.sv */
// Bit clock and reset source for the AC97 testbench
// 40 ns bit clock, reset held low for the first 8 rising edges

module tb_clock_gen (
	output logic ac97_bitclk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int half_period  = 20;
	localparam int reset_cycles = 8;

	initial begin
		ac97_bitclk = 1'b0;
		forever #half_period ac97_bitclk = ~ac97_bitclk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge ac97_bitclk);
		rst_n <= 1'b1;  // Released on a rising edge
	end

endmodule
